/* Bender.yml */
package:
  name: router

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/router_pkg.sv
      - verilog/router_input_decode.sv
      - verilog/router_arbiter.sv
      - verilog/router_crossbar.sv
      - verilog/router.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/router_asserts.sv
      - test/router_tb.sv

/* router.f */
+incdir+verilog
verilog/router_pkg.sv
verilog/router_input_decode.sv
verilog/router_arbiter.sv
verilog/router_crossbar.sv
verilog/router.sv
test/router_asserts.sv
test/router_tb.sv

/* test/router_asserts.sv */
`include "router_params.svh"

module router_asserts (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input router_pkg::port_vec_t          gnt_i [`ROUTER_PORTS],
  input router_pkg::port_vec_t          req_i [`ROUTER_PORTS],
  input logic [`ROUTER_PORTS-1:0]       frame_n_i,
  input logic [`ROUTER_PORTS-1:0]       valid_n_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Assertion failure count
  int fire_cnt = 0;

  // Grant bits regrouped per input, one bit per output
  router_pkg::port_vec_t gnt_by_in [`ROUTER_PORTS];

  for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_col
    for (genvar d = 0; d < `ROUTER_PORTS; d++) begin : g_row
      assign gnt_by_in[i][d] = gnt_i[d][i];
    end
  end

  for (genvar p = 0; p < `ROUTER_PORTS; p++) begin : g_chk
    a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_i[p]))
    else begin
      $error("Output %0d holds more than one grant", p);
      fire_cnt++;
    end

    a_gnt_unique : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_by_in[p]))
    else begin
      $error("Input %0d is granted by more than one output", p);
      fire_cnt++;
    end

    // Valid only inside an open frame
    a_valid_in_frame : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(!valid_n_i[p] && frame_n_i[p]))
    else begin
      $error("Output %0d shows valid with frame high", p);
      fire_cnt++;
    end

    a_req_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(req_i[p]))
    else begin
      $error("Decoder %0d requests more than one output", p);
      fire_cnt++;
    end
  end

endmodule

/* test/router_tb.sv */
`include "router_params.svh"

module router_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int P    = `ROUTER_PORTS;
  localparam int MAXC = 1024;

  logic         clk;
  logic         rst_n;
  logic [P-1:0] din;
  logic [P-1:0] frame_n;
  logic [P-1:0] valid_n;
  logic [P-1:0] dout;
  logic [P-1:0] frame_n_out;
  logic [P-1:0] valid_n_out;

  // Per-cycle stimulus and expected outputs of the running test
  logic [P-1:0] stim_din   [MAXC];
  logic [P-1:0] stim_frame [MAXC];
  logic [P-1:0] stim_valid [MAXC];
  logic [P-1:0] exp_dout   [MAXC];
  logic [P-1:0] exp_frame  [MAXC];
  logic [P-1:0] exp_valid  [MAXC];

  // Packet index by input and start cycle (-1 where none starts)
  int          start_at [P][MAXC];
  int          pk_dst [$];
  int          pk_len [$];
  logic [23:0] pk_data [$];
  int          sched_end;

  int cycle_cnt   = 0;
  int cycle_limit = 200;
  int err_cnt     = 0;
  int tests_ok    = 0;
  int tests_bad   = 0;
  int test_num    = 0;

  router i_router (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .din_i     (din),
    .frame_n_i (frame_n),
    .valid_n_i (valid_n),
    .dout_o    (dout),
    .frame_n_o (frame_n_out),
    .valid_n_o (valid_n_out)
  );

  bind router router_asserts i_router_asserts (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .gnt_i     (gnt_by_out),
    .req_i     (req_by_in),
    .frame_n_i (frame_n_o),
    .valid_n_i (valid_n_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run exceeded %0d clock cycles", cycle_limit);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Schedule and reference model
  ////////////////////////////////////////////////////////////

  task automatic clear_schedule();
    for (int k = 0; k < MAXC; k++) begin
      stim_din[k]   = '0;
      stim_frame[k] = '1;
      stim_valid[k] = '1;
      exp_dout[k]   = '0;
      exp_frame[k]  = '1;
      exp_valid[k]  = '1;
      for (int i = 0; i < P; i++) begin
        start_at[i][k] = -1;
      end
    end
    pk_dst.delete();
    pk_len.delete();
    pk_data.delete();
    sched_end = 4;
  endtask

  // Address LSB first in cycles s..s+3 and the payload after it
  task automatic add_packet(input int src, input int s, input int dst, input int len,
                            input logic [23:0] data);
    for (int k = 0; k < `ROUTER_ADDR_W; k++) begin
      stim_frame[s+k][src] = 1'b0;
      stim_din[s+k][src]   = dst[k];
    end
    for (int j = 0; j < len; j++) begin
      stim_din[s+4+j][src]   = data[j];
      stim_valid[s+4+j][src] = 1'b0;
      stim_frame[s+4+j][src] = (j == len - 1);
    end
    start_at[src][s] = pk_dst.size();
    pk_dst.push_back(dst);
    pk_len.push_back(len);
    pk_data.push_back(data);
    if (s + 4 + len > sched_end) begin
      sched_end = s + 4 + len;
    end
    cycle_limit += len + 4 + 8;
  endtask

  // Request decided at edge s+5
  // Output free again from edge s+8+len
  task automatic predict_delivery();
    int free_edge [P];
    int p;
    int d;
    for (int i = 0; i < P; i++) begin
      free_edge[i] = 0;
    end
    for (int s = 0; s < MAXC; s++) begin
      for (int i = 0; i < P; i++) begin
        p = start_at[i][s];
        if (p >= 0) begin
          d = pk_dst[p];
          if (s + 5 >= free_edge[d]) begin
            free_edge[d] = s + 8 + pk_len[p];
            for (int j = 0; j < pk_len[p]; j++) begin
              exp_dout[s+8+j][d]  = pk_data[p][j];
              exp_frame[s+8+j][d] = 1'b0;
              exp_valid[s+8+j][d] = 1'b0;
            end
          end
        end
      end
    end
  endtask

  task automatic check_value(input string name, input logic [P-1:0] expected,
                             input logic [P-1:0] actual);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic run_schedule(input string name);
    int n;
    int errs_before;
    n = sched_end + 12;
    errs_before = err_cnt;
    predict_delivery();
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #2;
      check_value("dout_o", exp_dout[k], dout);
      check_value("frame_n_o", exp_frame[k], frame_n_out);
      check_value("valid_n_o", exp_valid[k], valid_n_out);
      din     = stim_din[k];
      frame_n = stim_frame[k];
      valid_n = stim_valid[k];
    end
    test_num++;
    if (err_cnt == errs_before) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("Test %0d %s finished with %0d errors", test_num, name, err_cnt - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic shuffle_ports(output int perm [P]);
    int j;
    int tmp;
    for (int i = 0; i < P; i++) begin
      perm[i] = i;
    end
    for (int i = P - 1; i > 0; i--) begin
      j = $urandom % (i + 1);
      tmp = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp;
    end
  endtask

  task automatic single_packets();
    int s;
    int len;
    clear_schedule();
    s = 0;
    for (int i = 0; i < P; i++) begin
      len = 1 + $urandom % 24;
      add_packet(i, s, $urandom % P, len, 24'($urandom));
      s += len + 12;
    end
    run_schedule("single packets");
  endtask

  task automatic all_inputs_at_once();
    int perm [P];
    clear_schedule();
    shuffle_ports(perm);
    for (int i = 0; i < P; i++) begin
      add_packet(i, 0, perm[i], 1 + $urandom % 24, 24'($urandom));
    end
    run_schedule("all inputs at once");
  endtask

  task automatic same_output_contention();
    int pick [P];
    int n;
    int dst;
    int s;
    clear_schedule();
    s = 0;
    for (int r = 0; r < 3; r++) begin
      shuffle_ports(pick);
      n = 2 + $urandom % 3;
      dst = $urandom % P;
      for (int k = 0; k < n; k++) begin
        add_packet(pick[k], s, dst, 1 + $urandom % 24, 24'($urandom));
      end
      s += 36;
    end
    run_schedule("same output contention");
  endtask

  task automatic busy_and_back_to_back();
    int outs [P];
    int a;
    int b;
    int dst;
    int s;
    int len;
    clear_schedule();
    a = $urandom % P;
    b = (a + 1 + $urandom % (P - 1)) % P;
    dst = $urandom % P;
    add_packet(a, 0, dst, 12, 24'($urandom));
    // Second request lands while the output is still held
    add_packet(b, 1 + $urandom % 10, dst, 1 + $urandom % 24, 24'($urandom));
    shuffle_ports(outs);
    s = 40;
    for (int k = 0; k < 3; k++) begin
      len = 1 + $urandom % 24;
      add_packet(a, s, outs[k], len, 24'($urandom));
      s += 4 + len;
    end
    run_schedule("busy output and back to back");
  endtask

  task automatic random_traffic();
    int s;
    int len;
    clear_schedule();
    for (int i = 0; i < P; i++) begin
      s = $urandom % 8;
      len = 1 + $urandom % 24;
      while (s + 4 + len <= 300) begin
        add_packet(i, s, $urandom % P, len, 24'($urandom));
        s += 4 + len + $urandom % 10;
        len = 1 + $urandom % 24;
      end
    end
    run_schedule("random traffic");
  endtask

  initial begin
    void'($urandom(76));
    rst_n   = 1'b0;
    din     = '0;
    frame_n = '1;
    valid_n = '1;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    clear_schedule();
    run_schedule("idle after reset");
    single_packets();
    all_inputs_at_once();
    same_output_contention();
    busy_and_back_to_back();
    random_traffic();

    $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_ok, tests_bad, i_router.i_router_asserts.fire_cnt);
    if (tests_bad == 0 && i_router.i_router_asserts.fire_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog/router.sv */
`include "router_params.svh"

module router (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`ROUTER_PORTS-1:0] din_i,
  input  logic [`ROUTER_PORTS-1:0] frame_n_i,
  input  logic [`ROUTER_PORTS-1:0] valid_n_i,
  output logic [`ROUTER_PORTS-1:0] dout_o,
  output logic [`ROUTER_PORTS-1:0] frame_n_o,
  output logic [`ROUTER_PORTS-1:0] valid_n_o
);

  // Request vectors per input, then per output
  wire router_pkg::port_vec_t req_by_in  [`ROUTER_PORTS];
  wire router_pkg::port_vec_t req_by_out [`ROUTER_PORTS];
  wire router_pkg::port_vec_t gnt_by_out [`ROUTER_PORTS];

  // Delayed payload streams, bit i from input i
  wire router_pkg::port_vec_t pay_bit;
  wire router_pkg::port_vec_t pay_valid;
  wire router_pkg::port_vec_t pay_last;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_in
    router_input_decode i_decode (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .din_i       (din_i[i]),
      .frame_n_i   (frame_n_i[i]),
      .valid_n_i   (valid_n_i[i]),
      .req_o       (req_by_in[i]),
      .pay_bit_o   (pay_bit[i]),
      .pay_valid_o (pay_valid[i]),
      .pay_last_o  (pay_last[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  for (genvar d = 0; d < `ROUTER_PORTS; d++) begin : g_out
    // Transpose, bit i of output d's request comes from input i
    for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_req
      assign req_by_out[d][i] = req_by_in[i][d];
    end

    router_arbiter i_arbiter (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (req_by_out[d]),
      .last_i  (pay_last),
      .gnt_o   (gnt_by_out[d])
    );

    router_crossbar i_crossbar (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .gnt_i     (gnt_by_out[d]),
      .bit_i     (pay_bit),
      .valid_i   (pay_valid),
      .last_i    (pay_last),
      .dout_o    (dout_o[d]),
      .frame_n_o (frame_n_o[d]),
      .valid_n_o (valid_n_o[d])
    );
  end

endmodule

/* verilog/router_arbiter.sv */
`include "router_params.svh"

module router_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  router_pkg::port_vec_t req_i,
  input  router_pkg::port_vec_t last_i,
  output router_pkg::port_vec_t gnt_o
);

  router_pkg::port_vec_t pick;
  logic                  free;
  logic                  done;

  // Output holds no grant
  assign free = ~|gnt_o;

  // Granted stream shows its last bit
  assign done = |(gnt_o & last_i);

  // Fixed priority, lowest index wins
  always_comb begin
    pick = '0;
    for (int i = `ROUTER_PORTS - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        pick = router_pkg::port_vec_t'(1) << i;
      end
    end
  end

  // Requests seen while busy or releasing are dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_o <= '0;
    end else if (done) begin
      gnt_o <= '0;
    end else if (free) begin
      gnt_o <= pick;
    end
  end

endmodule

/* verilog/router_crossbar.sv */
module router_crossbar (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  router_pkg::port_vec_t gnt_i,
  input  router_pkg::port_vec_t bit_i,
  input  router_pkg::port_vec_t valid_i,
  input  router_pkg::port_vec_t last_i,
  output logic                  dout_o,
  output logic                  frame_n_o,
  output logic                  valid_n_o
);

  logic granted;
  logic sel_bit;
  logic sel_valid;
  logic sel_last;
  logic frame_low;

  assign granted = |gnt_i;

  // AND-OR mux, grant is at most one-hot
  assign sel_bit   = |(gnt_i & bit_i);
  assign sel_valid = |(gnt_i & valid_i);
  assign sel_last  = |(gnt_i & last_i);

  // Frame opens on the first bit and stays open across gaps;
  // a stream closed without a bit ends it at once
  assign frame_low = granted & (sel_valid | (~frame_n_o & ~sel_last));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dout_o    <= 1'b0;
      frame_n_o <= 1'b1;
      valid_n_o <= 1'b1;
    end else begin
      dout_o    <= sel_bit & sel_valid;
      frame_n_o <= ~frame_low;
      valid_n_o <= ~sel_valid;
    end
  end

endmodule

/* verilog/router_input_decode.sv */
`include "router_params.svh"

module router_input_decode (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  din_i,
  input  logic                  frame_n_i,
  input  logic                  valid_n_i,
  output router_pkg::port_vec_t req_o,
  output logic                  pay_bit_o,
  output logic                  pay_valid_o,
  output logic                  pay_last_o
);

  typedef logic [$clog2(`ROUTER_ADDR_W)-1:0] cnt_t;

  router_pkg::decode_state_e state_q;
  router_pkg::decode_state_e state_d;
  cnt_t                      addr_cnt_q;
  router_pkg::port_idx_t     addr_q;
  router_pkg::port_idx_t     addr_full;
  logic                      addr_done;

  // Capture stage plus two delay stages
  logic [2:0] bit_q;
  logic [2:0] valid_q;
  logic [2:0] last_q;
  logic       cap_valid;
  logic       cap_last;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  // Shift right so the LSB ends up at bit 0
  assign addr_full = {din_i, addr_q[`ROUTER_ADDR_W-1:1]};

  // Last address bit, frame still low
  assign addr_done = (state_q == router_pkg::ADDR) &&
                     (addr_cnt_q == cnt_t'(`ROUTER_ADDR_W - 1)) &&
                     !frame_n_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      router_pkg::IDLE: begin
        // First address bit is taken in this cycle
        if (!frame_n_i) begin
          state_d = router_pkg::ADDR;
        end
      end
      router_pkg::ADDR: begin
        // Frame ending inside the address is a broken packet
        if (frame_n_i) begin
          state_d = router_pkg::DISCARD;
        end else if (addr_done) begin
          state_d = router_pkg::PAYLOAD;
        end
      end
      router_pkg::PAYLOAD: begin
        if (frame_n_i) begin
          state_d = router_pkg::IDLE;
        end
      end
      router_pkg::DISCARD: begin
        if (frame_n_i) begin
          state_d = router_pkg::IDLE;
        end
      end
      default: begin
        state_d = router_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= router_pkg::IDLE;
      addr_cnt_q <= '0;
      req_o      <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == router_pkg::ADDR) begin
        addr_cnt_q <= addr_cnt_q + cnt_t'(1);
      end else begin
        addr_cnt_q <= cnt_t'(1);
      end
      // One-cycle request pulse towards the addressed output
      if (addr_done) begin
        req_o <= router_pkg::port_vec_t'(1) << addr_full;
      end else begin
        req_o <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == router_pkg::IDLE) || (state_q == router_pkg::ADDR)) begin
      addr_q <= addr_full;
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload delay line
  ////////////////////////////////////////////////////////////

  assign cap_valid = (state_q == router_pkg::PAYLOAD) && !valid_n_i;
  // An early frame end also closes the stream
  assign cap_last  = (state_q == router_pkg::PAYLOAD) && frame_n_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      last_q  <= '0;
    end else begin
      valid_q <= {valid_q[1:0], cap_valid};
      last_q  <= {last_q[1:0], cap_last};
    end
  end

  always_ff @(posedge clk_i) begin
    bit_q <= {bit_q[1:0], din_i};
  end

  assign pay_bit_o   = bit_q[2];
  assign pay_valid_o = valid_q[2];
  assign pay_last_o  = last_q[2];

endmodule

/* verilog/router_params.svh */
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// Input and output port count of the router
`define ROUTER_PORTS 16

// Destination address, sent LSB first at the head of a packet
`define ROUTER_ADDR_W 4

`endif

/* verilog/router_pkg.sv */
`include "router_params.svh"

package router_pkg;

  // Index of one port
  typedef logic [`ROUTER_ADDR_W-1:0] port_idx_t;

  // One bit per port, for request and grant vectors
  typedef logic [`ROUTER_PORTS-1:0] port_vec_t;

  // Per-input decoder states
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ADDR    = 2'd1,
    PAYLOAD = 2'd2,
    DISCARD = 2'd3
  } decode_state_e;

endpackage
